/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = data_cache_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
PASS_MSG  = *** PASSED ***

.PHONY: sim clean

# Build and run, the status comes from searching the output for the pass message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q -F '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* hw/cache_block.sv */
// Data memory of one way, banked into word-wide chips with byte writes and chip-selected reads
`timescale 1ns/1ps
`include "dcache_params.svh"

module cache_block (
    input  logic                  clk_i,

    // Port 0, write only towards the data chips
    input  dcache_pkg::chip_sel_t p0_chip_i,
    input  dcache_pkg::index_t    p0_index_i,
    input  dcache_pkg::byte_en_t  p0_byte_en_i,
    input  dcache_pkg::word_t     p0_word_i,
    input  logic                  p0_we_i,

    // Port 1, read only
    input  dcache_pkg::chip_sel_t p1_chip_i,
    input  dcache_pkg::index_t    p1_index_i,
    input  logic                  p1_re_i,
    output dcache_pkg::word_t     p1_word_o
);

    localparam int SETS  = 1 << `DC_SETS_LOG2;
    localparam int CHIPS = 1 << `DC_CHIPS_LOG2;
    localparam int BYTES = `DC_BYTES;

    // Read register of every chip, gathered for the output mux
    logic [CHIPS-1:0][`DC_WORD_BITS-1:0] chip_words;

    // Remembers which chip port 1 read last, it steers the output
    dcache_pkg::chip_sel_t chip_q;

    // ----------------------------------------
    // One memory per chip
    // ----------------------------------------
    for (genvar c = 0; c < CHIPS; c++) begin : g_chip

        // Holds word c of every line
        dcache_pkg::word_t mem [SETS];
        dcache_pkg::word_t rd_q;

        // Only the addressed chip sees the write, and only its enabled bytes change
        always_ff @(posedge clk_i) begin
            if (p0_we_i && (p0_chip_i == dcache_pkg::chip_sel_t'(c))) begin
                for (int b = 0; b < BYTES; b++) begin
                    if (p0_byte_en_i[b]) begin
                        mem[p0_index_i][b*8 +: 8] <= p0_word_i[b*8 +: 8];
                    end
                end
            end
        end

        // Reading just the selected chip keeps the other banks idle
        always_ff @(posedge clk_i) begin
            if (p1_re_i && (p1_chip_i == dcache_pkg::chip_sel_t'(c))) begin
                rd_q <= mem[p1_index_i];
            end
        end

        assign chip_words[c] = rd_q;
    end

    // The select is registered with the read so it lines up with the chip outputs
    always_ff @(posedge clk_i) begin
        if (p1_re_i) begin
            chip_q <= p1_chip_i;
        end
    end

    assign p1_word_o = chip_words[chip_q];

    // A data write with no byte enabled means the caller built a broken request
    a_mask_nonzero : assert property (
        @(posedge clk_i) p0_we_i |-> (p0_byte_en_i != '0)
    );

endmodule : cache_block

/* hw/cache_way.sv */
// One cache way joining its status, tag and data memories behind a two-port interface
`timescale 1ns/1ps

module cache_way (
    input  logic    clk_i,
    input  logic    arst_n_i,
    input  logic    enable_way_i,
    way_port_if.way bus
);

    // Write strobe of this way only, reads are not gated by the way select
    logic p0_write;

    // Fields coming back from the memories
    logic              p0_valid;
    logic              p0_dirty;
    dcache_pkg::tag_t  p0_tag;
    logic              p1_valid;
    logic              p1_dirty;
    dcache_pkg::tag_t  p1_tag;
    dcache_pkg::word_t p1_word;

    assign p0_write = bus.p0_write & enable_way_i;

    // ----------------------------------------
    // Memories of the way
    // ----------------------------------------

    // Each memory only moves when its enable bit is set in the request
    status_memory u_status (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .p0_index_i    (bus.p0_index),
        .p0_valid_i    (bus.p0_packet_in.valid),
        .p0_dirty_i    (bus.p0_packet_in.dirty),
        .p0_valid_we_i (p0_write & bus.p0_enable.valid),
        .p0_dirty_we_i (p0_write & bus.p0_enable.dirty),
        .p0_valid_re_i (bus.p0_read & bus.p0_enable.valid),
        .p0_dirty_re_i (bus.p0_read & bus.p0_enable.dirty),
        .p0_valid_o    (p0_valid),
        .p0_dirty_o    (p0_dirty),
        .p1_index_i    (bus.p1_index),
        // Port 1 reads its status on its own strobe
        .p1_valid_re_i (bus.p1_read & bus.p1_enable.valid),
        .p1_dirty_re_i (bus.p1_read & bus.p1_enable.dirty),
        .p1_valid_o    (p1_valid),
        .p1_dirty_o    (p1_dirty)
    );

    tag_memory u_tag (
        .clk_i      (clk_i),
        .p0_index_i (bus.p0_index),
        .p0_tag_i   (bus.p0_packet_in.tag),
        .p0_we_i    (p0_write & bus.p0_enable.tag),
        .p0_re_i    (bus.p0_read & bus.p0_enable.tag),
        .p0_tag_o   (p0_tag),
        .p1_index_i (bus.p1_index),
        .p1_re_i    (bus.p1_read & bus.p1_enable.tag),
        .p1_tag_o   (p1_tag)
    );

    // The data chips have no port 0 read path
    cache_block u_block (
        .clk_i        (clk_i),
        .p0_chip_i    (bus.p0_chip),
        .p0_index_i   (bus.p0_index),
        .p0_byte_en_i (bus.p0_byte_en),
        .p0_word_i    (bus.p0_packet_in.word),
        .p0_we_i      (p0_write & bus.p0_enable.data),
        .p1_chip_i    (bus.p1_chip),
        .p1_index_i   (bus.p1_index),
        .p1_re_i      (bus.p1_read & bus.p1_enable.data),
        .p1_word_o    (p1_word)
    );

    // Port 0 word reads as zero
    assign bus.p0_packet_out = '{valid: p0_valid, dirty: p0_dirty, tag: p0_tag, word: '0};
    assign bus.p1_packet_out = '{valid: p1_valid, dirty: p1_dirty, tag: p1_tag, word: p1_word};

    // Port 0 is a single port, a read and a write cannot share one edge
    a_p0_exclusive : assert property (
        @(posedge clk_i) disable iff (!arst_n_i) !(bus.p0_write && bus.p0_read)
    );

endmodule : cache_way

/* hw/data_cache.sv */
// Top level cache array with way decode for port 0, parallel lookup and hit resolution
`timescale 1ns/1ps
`include "dcache_params.svh"

module data_cache (
    input  logic                  clk_i,
    input  logic                  arst_n_i,

    // Port 0 does maintenance reads and writes of one way
    input  dcache_pkg::way_t      port0_way_i,
    input  dcache_pkg::enable_t   port0_enable_i,
    input  dcache_pkg::index_t    port0_index_i,
    input  dcache_pkg::chip_sel_t port0_chip_i,
    input  dcache_pkg::byte_en_t  port0_byte_en_i,
    input  dcache_pkg::packet_t   port0_packet_i,
    input  logic                  port0_write_i,
    input  logic                  port0_read_i,
    output logic                  port0_valid_o,
    output logic                  port0_dirty_o,
    output dcache_pkg::tag_t      port0_tag_o,

    // Lookup over all ways
    input  logic                  lookup_i,
    input  dcache_pkg::index_t    lookup_index_i,
    input  dcache_pkg::chip_sel_t lookup_chip_i,
    input  dcache_pkg::tag_t      lookup_tag_i,
    output logic                  lookup_done_o,
    output logic                  hit_o,
    output dcache_pkg::way_t      hit_way_o,
    output logic                  hit_dirty_o,
    output dcache_pkg::word_t     hit_word_o
);

    localparam int WAYS = `DC_WAYS;

    logic [WAYS-1:0]     way_en;
    logic [WAYS-1:0]     hit_vec;
    dcache_pkg::packet_t p0_pkt [WAYS];
    dcache_pkg::packet_t p1_pkt [WAYS];
    dcache_pkg::packet_t p0_sel;
    dcache_pkg::packet_t hit_pkt;
    dcache_pkg::way_t    rd_way_q;
    dcache_pkg::way_t    hit_way;
    dcache_pkg::tag_t    tag_q;
    logic                lookup_q;

    // ----------------------------------------
    // Ways
    // ----------------------------------------
    for (genvar w = 0; w < WAYS; w++) begin : g_way
        way_port_if bus ();

        // Only the addressed way takes a port 0 write
        assign way_en[w] = (port0_way_i == dcache_pkg::way_t'(w));

        assign bus.p0_enable    = port0_enable_i;
        assign bus.p0_chip      = port0_chip_i;
        assign bus.p0_byte_en   = port0_byte_en_i;
        assign bus.p0_index     = port0_index_i;
        assign bus.p0_packet_in = port0_packet_i;
        assign bus.p0_write     = port0_write_i;
        assign bus.p0_read      = port0_read_i;

        // A lookup needs every field of every way
        assign bus.p1_enable = '{default: 1'b1};
        assign bus.p1_chip   = lookup_chip_i;
        assign bus.p1_index  = lookup_index_i;
        assign bus.p1_read   = lookup_i;

        cache_way u_way (
            .clk_i        (clk_i),
            .arst_n_i     (arst_n_i),
            .enable_way_i (way_en[w]),
            .bus          (bus)
        );

        assign p0_pkt[w] = bus.p0_packet_out;
        assign p1_pkt[w] = bus.p1_packet_out;

        // Memory outputs are one cycle old, so they meet the registered tag
        assign hit_vec[w] = p1_pkt[w].valid && (p1_pkt[w].tag == tag_q);
    end

    // ----------------------------------------
    // Request registers
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_way_q <= '0;
            lookup_q <= 1'b0;
        end else begin
            // Keep the way of the last port 0 read to pick its result
            if (port0_read_i) rd_way_q <= port0_way_i;
            lookup_q <= lookup_i;
        end
    end

    always_ff @(posedge clk_i) begin
        tag_q <= lookup_tag_i;
    end

    // ----------------------------------------
    // Results
    // ----------------------------------------
    assign p0_sel        = p0_pkt[rd_way_q];
    assign port0_valid_o = p0_sel.valid;
    assign port0_dirty_o = p0_sel.dirty;
    assign port0_tag_o   = p0_sel.tag;

    // Tags are unique per set, so the last match is the only one
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (hit_vec[w]) hit_way = dcache_pkg::way_t'(w);
        end
    end

    assign hit_pkt       = p1_pkt[hit_way];
    assign lookup_done_o = lookup_q;
    assign hit_o         = lookup_q & (|hit_vec);
    assign hit_way_o     = hit_way;
    // A miss reports a clean, zero word
    assign hit_dirty_o   = hit_o & hit_pkt.dirty;
    assign hit_word_o    = hit_o ? hit_pkt.word : '0;

    // Two ways holding the same tag in one set would make the hit ambiguous
    a_single_hit : assert property (
        @(posedge clk_i) disable iff (!arst_n_i) lookup_q |-> $onehot0(hit_vec)
    );

endmodule : data_cache

/* hw/dcache_pkg.sv */
// Cache package with width typedefs, the field enable struct and the cache packet struct
`include "dcache_params.svh"

package dcache_pkg;

    // ----------------------------------------
    // Plain vectors with a meaning
    // ----------------------------------------

    // Set index shared by all three memories of a way
    typedef logic [`DC_SETS_LOG2-1:0] index_t;

    // Selects one word (one chip) of a cache line
    typedef logic [`DC_CHIPS_LOG2-1:0] chip_sel_t;

    typedef logic [`DC_TAG_BITS-1:0] tag_t;

    typedef logic [`DC_WORD_BITS-1:0] word_t;

    // One bit per byte of a word
    typedef logic [`DC_BYTES-1:0] byte_en_t;

    // Way number, needs at least two ways to be non-empty
    typedef logic [$clog2(`DC_WAYS)-1:0] way_t;

    // ----------------------------------------
    // Structs travelling between the blocks
    // ----------------------------------------

    // Chooses which memories of a way take part in an access
    typedef struct packed {
        logic valid;
        logic dirty;
        logic tag;
        logic data;
    } enable_t;

    // Everything stored for one word of a line, 54 bits
    typedef struct packed {
        logic  valid;
        logic  dirty;
        tag_t  tag;
        word_t word;
    } packet_t;

endpackage : dcache_pkg

/* hw/status_memory.sv */
// Valid and dirty bit arrays with asynchronous reset, one read/write port and one read port
`timescale 1ns/1ps
`include "dcache_params.svh"

module status_memory (
    input  logic                clk_i,
    input  logic                arst_n_i,

    // Port 0, read and write
    input  dcache_pkg::index_t  p0_index_i,
    input  logic                p0_valid_i,
    input  logic                p0_dirty_i,
    input  logic                p0_valid_we_i,
    input  logic                p0_dirty_we_i,
    input  logic                p0_valid_re_i,
    input  logic                p0_dirty_re_i,
    output logic                p0_valid_o,
    output logic                p0_dirty_o,

    // Port 1, read only
    input  dcache_pkg::index_t  p1_index_i,
    input  logic                p1_valid_re_i,
    input  logic                p1_dirty_re_i,
    output logic                p1_valid_o,
    output logic                p1_dirty_o
);

    localparam int SETS = 1 << `DC_SETS_LOG2;

    // One bit per set, these must come up cleared so nothing hits after reset
    logic [SETS-1:0] valid_q;
    logic [SETS-1:0] dirty_q;

    // Both bits write and read on their own enables
    // Reads sample the array before the write of the same edge lands, so they see old data
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q    <= '0;
            dirty_q    <= '0;
            p0_valid_o <= 1'b0;
            p0_dirty_o <= 1'b0;
            p1_valid_o <= 1'b0;
            p1_dirty_o <= 1'b0;
        end else begin
            if (p0_valid_we_i) valid_q[p0_index_i] <= p0_valid_i;
            if (p0_dirty_we_i) dirty_q[p0_index_i] <= p0_dirty_i;
            // Outputs that are not read hold their last value
            if (p0_valid_re_i) p0_valid_o <= valid_q[p0_index_i];
            if (p0_dirty_re_i) p0_dirty_o <= dirty_q[p0_index_i];
            if (p1_valid_re_i) p1_valid_o <= valid_q[p1_index_i];
            if (p1_dirty_re_i) p1_dirty_o <= dirty_q[p1_index_i];
        end
    end

    // An unknown index on a write would corrupt status bits of unrelated sets
    a_index_known : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (p0_valid_we_i || p0_dirty_we_i) |-> !$isunknown(p0_index_i)
    );

endmodule : status_memory

/* hw/tag_memory.sv */
// Tag array with registered outputs, one read/write port and one read port
`timescale 1ns/1ps
`include "dcache_params.svh"

module tag_memory (
    input  logic                clk_i,

    // Port 0, read and write
    input  dcache_pkg::index_t  p0_index_i,
    input  dcache_pkg::tag_t    p0_tag_i,
    input  logic                p0_we_i,
    input  logic                p0_re_i,
    output dcache_pkg::tag_t    p0_tag_o,

    // Port 1, read only
    input  dcache_pkg::index_t  p1_index_i,
    input  logic                p1_re_i,
    output dcache_pkg::tag_t    p1_tag_o
);

    localparam int SETS = 1 << `DC_SETS_LOG2;

    // Behaves like a simple dual-port block RAM, so there is no reset
    dcache_pkg::tag_t mem [SETS];

    // ----------------------------------------
    // Port 0
    // ----------------------------------------

    // The read register takes the stored tag before this edge's write
    always_ff @(posedge clk_i) begin
        if (p0_we_i) begin
            mem[p0_index_i] <= p0_tag_i;
        end
        if (p0_re_i) begin
            p0_tag_o <= mem[p0_index_i];
        end
    end

    // ----------------------------------------
    // Port 1
    // ----------------------------------------

    // A lookup racing a port 0 write to the same set returns the old tag
    always_ff @(posedge clk_i) begin
        if (p1_re_i) begin
            p1_tag_o <= mem[p1_index_i];
        end
    end

endmodule : tag_memory

/* hw/way_port_if.sv */
// Interface carrying the maintenance port and the lookup port between the top and one way
`timescale 1ns/1ps

interface way_port_if;

    // ----------------------------------------
    // Port 0, read and write
    // ----------------------------------------
    dcache_pkg::enable_t   p0_enable;
    dcache_pkg::chip_sel_t p0_chip;
    dcache_pkg::byte_en_t  p0_byte_en;
    dcache_pkg::index_t    p0_index;
    dcache_pkg::packet_t   p0_packet_in;
    logic                  p0_write;
    logic                  p0_read;
    // Status and tag only, the word field is always zero
    dcache_pkg::packet_t   p0_packet_out;

    // ----------------------------------------
    // Port 1, read only
    // ----------------------------------------
    dcache_pkg::enable_t   p1_enable;
    dcache_pkg::chip_sel_t p1_chip;
    dcache_pkg::index_t    p1_index;
    logic                  p1_read;
    dcache_pkg::packet_t   p1_packet_out;

    // The top level side drives the requests
    modport ctrl (
        output p0_enable, p0_chip, p0_byte_en, p0_index, p0_packet_in, p0_write, p0_read,
        output p1_enable, p1_chip, p1_index, p1_read,
        input  p0_packet_out, p1_packet_out
    );

    // The way side answers them
    modport way (
        input  p0_enable, p0_chip, p0_byte_en, p0_index, p0_packet_in, p0_write, p0_read,
        input  p1_enable, p1_chip, p1_index, p1_read,
        output p0_packet_out, p1_packet_out
    );

endinterface : way_port_if

/* include/dcache_params.svh */
// Cache geometry macros for ways, sets, chips per line, word width and tag width
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// Number of ways, every way is a full copy of status, tag and data memories
`define DC_WAYS 2

// Set index width, 32 sets per way
`define DC_SETS_LOG2 5

// Word select inside a line, each word lives in its own memory chip
`define DC_CHIPS_LOG2 2

// Width of one data word and of one chip
`define DC_WORD_BITS 32

// Stored tag width
`define DC_TAG_BITS 20

// Bytes per word, one byte enable per byte
`define DC_BYTES (`DC_WORD_BITS / 8)

`endif

/* sim.f */
+incdir+include
hw/dcache_pkg.sv
hw/way_port_if.sv
hw/status_memory.sv
hw/tag_memory.sv
hw/cache_block.sv
hw/cache_way.sv
hw/data_cache.sv
test/data_cache_tb.sv

/* test/data_cache_tb.sv */
// Testbench for the cache array with clock, reset, LFSR, reference model, checks and watchdog
`timescale 1ns/1ps
`include "dcache_params.svh"

module data_cache_tb;

    localparam int WAYS  = `DC_WAYS;
    localparam int SETS  = 1 << `DC_SETS_LOG2;
    localparam int CHIPS = 1 << `DC_CHIPS_LOG2;
    localparam int N1 = 20, N2 = 16, N3 = 32, N4 = 24, N5 = 16, N6 = 16;
    // Cycles each test needs, the watchdog allows this plus a margin
    localparam int TOTAL_CYCLES = 10 + N1 + (WAYS * SETS + N2) * 8 + N3 * 2 + N4 * 2 + 3
                                  + N5 * 4 + N6 * 3;
    localparam int WATCHDOG_NS = TOTAL_CYCLES * 20 + 2000;

    logic clk_i, arst_n_i;
    dcache_pkg::way_t port0_way_i, hit_way_o;
    dcache_pkg::enable_t port0_enable_i;
    dcache_pkg::index_t port0_index_i, lookup_index_i;
    dcache_pkg::chip_sel_t port0_chip_i, lookup_chip_i;
    dcache_pkg::byte_en_t port0_byte_en_i;
    dcache_pkg::packet_t port0_packet_i;
    logic port0_write_i, port0_read_i, port0_valid_o, port0_dirty_o;
    dcache_pkg::tag_t port0_tag_o, lookup_tag_i;
    logic lookup_i, lookup_done_o, hit_o, hit_dirty_o;
    dcache_pkg::word_t hit_word_o;

    // Reference model of every way and set
    logic m_valid [WAYS][SETS];
    logic m_dirty [WAYS][SETS];
    dcache_pkg::tag_t m_tag [WAYS][SETS];
    dcache_pkg::word_t m_word [WAYS][SETS][CHIPS];

    // Results expected after the next rising edge
    logic exp_lookup, exp_hit, exp_dirty, exp_rd, exp_rd_valid, exp_rd_dirty;
    dcache_pkg::way_t exp_way;
    dcache_pkg::word_t exp_word;
    dcache_pkg::tag_t exp_rd_tag;
    int errors = 0;
    int checks = 0;
    logic [15:0] lfsr_q = 16'd17878;

    data_cache data_cache_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    // Taps 16, 14, 13 and 11, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    // A tag that no other way holds in this set, way -1 avoids all ways
    function automatic dcache_pkg::tag_t new_tag(input int way, input int set);
        dcache_pkg::tag_t t;
        logic             clash;
        t = '0;
        clash = 1'b1;
        while (clash) begin
            t = dcache_pkg::tag_t'(rand_bits(`DC_TAG_BITS));
            clash = 1'b0;
            for (int w = 0; w < WAYS; w++) begin
                if (w != way && m_tag[w][set] == t) clash = 1'b1;
            end
        end
        return t;
    endfunction

    function automatic dcache_pkg::packet_t make_packet(input logic v, input logic d,
                                                        input dcache_pkg::tag_t t,
                                                        input dcache_pkg::word_t w);
        return '{valid: v, dirty: d, tag: t, word: w};
    endfunction

    task automatic check(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL t=%0t %s: got %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    task automatic drive_idle();
        port0_way_i = '0;
        port0_enable_i = '0;
        port0_index_i = '0;
        port0_chip_i = '0;
        port0_byte_en_i = '1;
        port0_packet_i = '0;
        port0_write_i = 1'b0;
        port0_read_i = 1'b0;
        lookup_i = 1'b0;
        lookup_index_i = '0;
        lookup_chip_i = '0;
        lookup_tag_i = '0;
    endtask

    // Waits one edge, checks what it produced, then frees the inputs 2 ns after it
    task automatic next_cycle();
        @(posedge clk_i);
        #1;
        check("lookup_done_o", 64'(lookup_done_o), 64'(exp_lookup));
        if (exp_lookup) begin
            check("hit_o", 64'(hit_o), 64'(exp_hit));
            if (exp_hit) check("hit_way_o", 64'(hit_way_o), 64'(exp_way));
            check("hit_dirty_o", 64'(hit_dirty_o), 64'(exp_dirty));
            check("hit_word_o", 64'(hit_word_o), 64'(exp_word));
        end
        if (exp_rd) begin
            check("port0_valid_o", 64'(port0_valid_o), 64'(exp_rd_valid));
            check("port0_dirty_o", 64'(port0_dirty_o), 64'(exp_rd_dirty));
            check("port0_tag_o", 64'(port0_tag_o), 64'(exp_rd_tag));
        end
        exp_lookup = 1'b0;
        exp_rd = 1'b0;
        #1;
        drive_idle();
    endtask

    // The expectation is taken from the model before a write of the same edge lands
    task automatic issue_lookup(input int set, input int chip, input dcache_pkg::tag_t tag);
        exp_hit = 1'b0;
        exp_way = '0;
        exp_dirty = 1'b0;
        exp_word = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (m_valid[w][set] && m_tag[w][set] == tag) begin
                exp_hit = 1'b1;
                exp_way = dcache_pkg::way_t'(w);
                exp_dirty = m_dirty[w][set];
                exp_word = m_word[w][set][chip];
            end
        end
        exp_lookup = 1'b1;
        lookup_i = 1'b1;
        lookup_index_i = dcache_pkg::index_t'(set);
        lookup_chip_i = dcache_pkg::chip_sel_t'(chip);
        lookup_tag_i = tag;
    endtask

    task automatic issue_write(input int way, input logic [3:0] en, input int set,
                               input int chip, input dcache_pkg::byte_en_t be,
                               input dcache_pkg::packet_t pkt);
        dcache_pkg::enable_t e;
        e = dcache_pkg::enable_t'(en);
        port0_way_i = dcache_pkg::way_t'(way);
        port0_enable_i = e;
        port0_index_i = dcache_pkg::index_t'(set);
        port0_chip_i = dcache_pkg::chip_sel_t'(chip);
        port0_byte_en_i = be;
        port0_packet_i = pkt;
        port0_write_i = 1'b1;
        if (e.valid) m_valid[way][set] = pkt.valid;
        if (e.dirty) m_dirty[way][set] = pkt.dirty;
        if (e.tag) m_tag[way][set] = pkt.tag;
        for (int b = 0; b < `DC_BYTES; b++) begin
            if (e.data && be[b]) m_word[way][set][chip][b*8 +: 8] = pkt.word[b*8 +: 8];
        end
    endtask

    task automatic issue_read(input int way, input int set);
        exp_rd = 1'b1;
        exp_rd_valid = m_valid[way][set];
        exp_rd_dirty = m_dirty[way][set];
        exp_rd_tag = m_tag[way][set];
        port0_way_i = dcache_pkg::way_t'(way);
        port0_enable_i = dcache_pkg::enable_t'(4'b1110);
        port0_index_i = dcache_pkg::index_t'(set);
        port0_read_i = 1'b1;
    endtask

    // Full line write, one chip per cycle, then every chip looked up back to back
    task automatic fill_line(input int way, input int set);
        dcache_pkg::tag_t tag;
        logic             dirty;
        tag = new_tag(way, set);
        dirty = 1'(rand_bits(1));
        for (int c = 0; c < CHIPS; c++) begin
            issue_write(way, 4'b1111, set, c, '1,
                        make_packet(1'b1, dirty, tag, dcache_pkg::word_t'(rand_bits(32))));
            next_cycle();
        end
        for (int c = 0; c < CHIPS; c++) begin
            issue_lookup(set, c, tag);
            next_cycle();
        end
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    initial begin
        int w, s, c;
        dcache_pkg::byte_en_t be;
        exp_lookup = 1'b0;
        exp_rd = 1'b0;
        for (int i = 0; i < WAYS; i++) begin
            for (int j = 0; j < SETS; j++) begin
                m_valid[i][j] = 1'b0;
                m_dirty[i][j] = 1'b0;
                m_tag[i][j] = '0;
            end
        end
        arst_n_i = 1'b0;
        drive_idle();
        repeat (10) @(posedge clk_i);
        #2 arst_n_i = 1'b1;

        // Test 1, nothing is valid so every lookup misses
        repeat (N1) begin
            issue_lookup(int'(rand_bits(5)), int'(rand_bits(2)),
                         dcache_pkg::tag_t'(rand_bits(`DC_TAG_BITS)));
            next_cycle();
        end

        // Test 2, every line is filled once, then random lines are refilled
        for (int i = 0; i < WAYS; i++) begin
            for (int j = 0; j < SETS; j++) fill_line(i, j);
        end
        repeat (N2) fill_line(int'(rand_bits(1)), int'(rand_bits(5)));

        // Test 3, byte-masked data writes merge into the stored word
        repeat (N3) begin
            w = int'(rand_bits(1));
            s = int'(rand_bits(5));
            c = int'(rand_bits(2));
            be = dcache_pkg::byte_en_t'(rand_bits(`DC_BYTES));
            if (be == '0) be = 4'b0001;
            issue_write(w, 4'b0001, s, c, be,
                        make_packet(1'b0, 1'b0, '0, dcache_pkg::word_t'(rand_bits(32))));
            next_cycle();
            issue_lookup(s, c, m_tag[w][s]);
            next_cycle();
        end

        // Test 4, dirty cleared alone, then random field subsets with a read and a lookup
        issue_write(0, 4'b0100, 3, 0, '1, make_packet(1'b0, 1'b0, '1, '0));
        next_cycle();
        issue_read(0, 3);
        next_cycle();
        repeat (N4) begin
            w = int'(rand_bits(1));
            s = int'(rand_bits(5));
            issue_write(w, {3'(rand_bits(3)), 1'b0}, s, 0, '1,
                        make_packet(1'(rand_bits(1)), 1'(rand_bits(1)), new_tag(w, s), '0));
            next_cycle();
            issue_read(w, s);
            issue_lookup(s, int'(rand_bits(2)), m_tag[w][s]);
            next_cycle();
        end

        // Test 5, foreign tags miss, and so does a line whose valid bit was cleared
        repeat (N5) begin
            w = int'(rand_bits(1));
            s = int'(rand_bits(5));
            c = int'(rand_bits(2));
            issue_lookup(s, c, new_tag(-1, s));
            next_cycle();
            issue_write(w, 4'b1000, s, 0, '1, make_packet(1'b0, 1'b0, '0, '0));
            next_cycle();
            issue_lookup(s, c, m_tag[w][s]);
            next_cycle();
            issue_write(w, 4'b1000, s, 0, '1, make_packet(1'b1, 1'b0, '0, '0));
            next_cycle();
        end

        // Test 6, a lookup racing a data write sees the old word, the next one the new
        repeat (N6) begin
            w = int'(rand_bits(1));
            s = int'(rand_bits(5));
            c = int'(rand_bits(2));
            issue_lookup(s, c, m_tag[w][s]);
            issue_write(w, 4'b0001, s, c, '1,
                        make_packet(1'b0, 1'b0, '0, dcache_pkg::word_t'(rand_bits(32))));
            next_cycle();
            issue_lookup(s, c, m_tag[w][s]);
            next_cycle();
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Stops a run that never reaches the end of the tests
    initial begin
        #WATCHDOG_NS;
        $display("Timeout: the tests did not reach their end in time");
        $display("*** FAILED ***");
        $finish;
    end

endmodule : data_cache_tb
